// File: rtl/pipe_trace_settings.svh
`ifndef PIPE_TRACE_SETTINGS_SVH
`define PIPE_TRACE_SETTINGS_SVH

// Fetch, decode, execute, memory, writeback
`define PT_NUM_STAGES 5

// Retire FIFO entries
`define PT_FIFO_DEPTH 8

// Free entries needed before issue is allowed
// Covers the five stage registers, the retire register and the issuing instruction
`define PT_ISSUE_MARGIN 7

// Field widths
`define PT_SEQ_W 8
`define PT_WORD_W 32
`define PT_STALL_W 4

// Statistics counter width
`define PT_TOTAL_W 16

`endif

// File: rtl/pipe_trace_pkg.sv
`include "pipe_trace_settings.svh"

package pipe_trace_pkg;

    // One pipeline stage register
    // Stall counts travel with the instruction from fetch onwards
    typedef struct packed {
        logic                   valid;
        logic [`PT_SEQ_W-1:0]   seq;
        logic [`PT_WORD_W-1:0]  word;
        logic [`PT_STALL_W-1:0] fetch_stalls;
        logic [`PT_STALL_W-1:0] decode_stalls;
    } stage_entry_t;

    // One retired instruction as stored in the retire FIFO
    typedef struct packed {
        logic [`PT_SEQ_W-1:0]   seq;
        logic [`PT_WORD_W-1:0]  word;
        logic [`PT_STALL_W-1:0] fetch_stalls;
        logic [`PT_STALL_W-1:0] decode_stalls;
    } retire_rec_t;

endpackage

// File: rtl/stage_tracker.sv
`timescale 1ns/100ps

`include "pipe_trace_settings.svh"

module stage_tracker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue,
    input  logic [`PT_WORD_W-1:0]       issue_word,
    input  logic                        stall,
    input  logic                        fifo_room,
    output logic                        fetch_free,
    output logic                        retire_valid,
    output pipe_trace_pkg::retire_rec_t retire_rec
);

    import pipe_trace_pkg::*;

    // Stage indices
    localparam int FE = 0;
    localparam int DE = 1;
    localparam int EX = 2;
    localparam int WB = `PT_NUM_STAGES - 1;

    stage_entry_t stg [`PT_NUM_STAGES];

    logic [`PT_SEQ_W-1:0] seq_cnt;
    logic                 fetch_adv;
    logic                 accept;
    stage_entry_t         new_entry;

    // Saturating stall counter step
    function automatic logic [`PT_STALL_W-1:0] sat_inc(
        input logic [`PT_STALL_W-1:0] cnt
    );
        if (&cnt) begin
            return cnt;
        end
        return cnt + 1'b1;
    endfunction

    // Fetch moves into decode whenever the front end is not frozen
    assign fetch_adv = ~stall;

    assign fetch_free = ~stall & fifo_room & (~stg[FE].valid | fetch_adv);

    // An issue pulse outside fetch_free is dropped
    assign accept = issue & fetch_free;

    always_comb begin
        new_entry               = '0;
        new_entry.valid         = 1'b1;
        new_entry.seq           = seq_cnt;
        new_entry.word          = issue_word;
        new_entry.fetch_stalls  = '0;
        new_entry.decode_stalls = '0;
    end

    // Sequence numbers follow accepted issues only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seq_cnt <= '0;
        end else if (accept) begin
            seq_cnt <= seq_cnt + 1'b1;
        end
    end

    // Front end: fetch and decode
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stg[FE] <= '0;
            stg[DE] <= '0;
        end else if (stall) begin
            // Frozen, each occupant counts the lost cycle
            if (stg[FE].valid) begin
                stg[FE].fetch_stalls <= sat_inc(stg[FE].fetch_stalls);
            end
            if (stg[DE].valid) begin
                stg[DE].decode_stalls <= sat_inc(stg[DE].decode_stalls);
            end
        end else begin
            stg[DE] <= stg[FE];
            if (accept) begin
                stg[FE] <= new_entry;
            end else begin
                stg[FE] <= '0;
            end
        end
    end

    // Execute gets a bubble while the front end is frozen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stg[EX] <= '0;
        end else if (stall) begin
            stg[EX] <= '0;
        end else begin
            stg[EX] <= stg[DE];
        end
    end

    // Memory and writeback never stop
    for (genvar i = EX + 1; i <= WB; i++) begin : g_back
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                stg[i] <= '0;
            end else begin
                stg[i] <= stg[i-1];
            end
        end
    end

    // Leaving writeback, one cycle pulse per instruction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= stg[WB].valid;
        end
    end

    always_ff @(posedge clk) begin
        if (stg[WB].valid) begin
            retire_rec.seq           <= stg[WB].seq;
            retire_rec.word          <= stg[WB].word;
            retire_rec.fetch_stalls  <= stg[WB].fetch_stalls;
            retire_rec.decode_stalls <= stg[WB].decode_stalls;
        end
    end

endmodule

// File: rtl/retire_fifo.sv
`timescale 1ns/100ps

`include "pipe_trace_settings.svh"

module retire_fifo (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr,
    input  pipe_trace_pkg::retire_rec_t wr_rec,
    input  logic                        rd,
    output pipe_trace_pkg::retire_rec_t rd_rec,
    output logic                        empty,
    output logic                        room
);

    import pipe_trace_pkg::*;

    localparam int DEPTH = `PT_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    retire_rec_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] free_cnt;
    logic             full;
    logic             do_wr;
    logic             do_rd;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign free_cnt = CNT_W'(DEPTH) - count;
    assign room     = (free_cnt >= CNT_W'(`PT_ISSUE_MARGIN));

    assign do_rd = rd & ~empty;
    // A read in the same cycle frees the slot being written
    assign do_wr = wr & (~full | do_rd);

    // Head of queue shows without a read request
    assign rd_rec = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_rec;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: rtl/retire_stats.sv
`timescale 1ns/100ps

`include "pipe_trace_settings.svh"

module retire_stats (
    input  logic                        clk,
    input  logic                        rst,
    input  pipe_trace_pkg::retire_rec_t fifo_rec,
    input  logic                        fifo_empty,
    input  logic                        log_hold,
    output logic                        pop,
    output logic                        rec_valid,
    output pipe_trace_pkg::retire_rec_t rec,
    output logic [`PT_TOTAL_W-1:0]      retired_count,
    output logic [`PT_TOTAL_W-1:0]      stall_total,
    output logic [`PT_TOTAL_W-1:0]      max_stall
);

    localparam int SUM_W = `PT_STALL_W + 1;

    logic [SUM_W-1:0]       rec_stall;
    logic [`PT_TOTAL_W-1:0] rec_stall_ext;

    // One record per cycle unless held off
    assign pop = ~fifo_empty & ~log_hold;

    // Stall cycles of the record at the FIFO head
    assign rec_stall = SUM_W'(fifo_rec.fetch_stalls) + SUM_W'(fifo_rec.decode_stalls);
    assign rec_stall_ext = {{(`PT_TOTAL_W - SUM_W){1'b0}}, rec_stall};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rec <= fifo_rec;
        end
    end

    // Totals move in the same cycle as the published record
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retired_count <= '0;
            stall_total   <= '0;
            max_stall     <= '0;
        end else if (pop) begin
            retired_count <= retired_count + 1'b1;
            stall_total   <= stall_total + rec_stall_ext;
            if (rec_stall_ext > max_stall) begin
                max_stall <= rec_stall_ext;
            end
        end
    end

endmodule

// File: rtl/pipe_trace_top.sv
`timescale 1ns/100ps

`include "pipe_trace_settings.svh"

module pipe_trace_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue,
    input  logic [`PT_WORD_W-1:0]       issue_word,
    input  logic                        stall,
    input  logic                        log_hold,
    output logic                        fetch_free,
    output logic                        rec_valid,
    output pipe_trace_pkg::retire_rec_t rec,
    output logic [`PT_TOTAL_W-1:0]      retired_count,
    output logic [`PT_TOTAL_W-1:0]      stall_total,
    output logic [`PT_TOTAL_W-1:0]      max_stall
);

    import pipe_trace_pkg::*;

    // Tracker to FIFO
    logic        retire_valid;
    retire_rec_t retire_rec;
    logic        fifo_room;

    // FIFO to statistics
    retire_rec_t fifo_rec;
    logic        fifo_empty;
    logic        pop;

    stage_tracker u_stage_tracker (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .issue_word   (issue_word),
        .stall        (stall),
        .fifo_room    (fifo_room),
        .fetch_free   (fetch_free),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec)
    );

    retire_fifo u_retire_fifo (
        .clk    (clk),
        .rst    (rst),
        .wr     (retire_valid),
        .wr_rec (retire_rec),
        .rd     (pop),
        .rd_rec (fifo_rec),
        .empty  (fifo_empty),
        .room   (fifo_room)
    );

    retire_stats u_retire_stats (
        .clk           (clk),
        .rst           (rst),
        .fifo_rec      (fifo_rec),
        .fifo_empty    (fifo_empty),
        .log_hold      (log_hold),
        .pop           (pop),
        .rec_valid     (rec_valid),
        .rec           (rec),
        .retired_count (retired_count),
        .stall_total   (stall_total),
        .max_stall     (max_stall)
    );

endmodule

// File: dv/pipe_trace_assert.sv
`timescale 1ns/100ps

module pipe_trace_assert (
    input logic clk,
    input logic rst,
    input logic issue,
    input logic fetch_free,
    input logic pop,
    input logic fifo_empty,
    input logic rec_valid
);

    // Issue only into a free fetch slot
    a_issue_free: assert property (@(posedge clk) disable iff (rst) issue |-> fetch_free)
        else $error("issue pulsed while fetch_free was low");

    a_pop_not_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !fifo_empty)
        else $error("pop while the retire FIFO was empty");

    // Nothing is published right after reset is released
    a_quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !rec_valid ##1 !rec_valid)
        else $error("rec_valid high just after reset");

endmodule

bind pipe_trace_top pipe_trace_assert u_pipe_trace_assert (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .fetch_free (fetch_free),
    .pop        (pop),
    .fifo_empty (fifo_empty),
    .rec_valid  (rec_valid)
);

// File: dv/pipe_trace_tb.sv
`timescale 1ns/100ps

`include "pipe_trace_settings.svh"

module pipe_trace_tb;

    import pipe_trace_pkg::*;

    localparam int FE          = 0;
    localparam int DE          = 1;
    localparam int EX          = 2;
    localparam int WB          = `PT_NUM_STAGES - 1;
    localparam int STALL_MAX   = (1 << `PT_STALL_W) - 1;
    localparam int DRAIN_LIMIT = 300;

    logic                   clk;
    logic                   rst;
    logic                   issue;
    logic [`PT_WORD_W-1:0]  issue_word;
    logic                   stall;
    logic                   log_hold;
    logic                   fetch_free;
    logic                   rec_valid;
    retire_rec_t            rec;
    logic [`PT_TOTAL_W-1:0] retired_count;
    logic [`PT_TOTAL_W-1:0] stall_total;
    logic [`PT_TOTAL_W-1:0] max_stall;

    integer seed;
    int     check_count;
    int     error_count;
    int     err_base;
    int     test_recs;
    int     first_seq;
    bit     timed_out;
    bit     saw_free_low;
    bit     sat_fetch_seen;
    bit     sat_decode_seen;

    // Reference model state
    stage_entry_t         model_stg [`PT_NUM_STAGES];
    logic [`PT_SEQ_W-1:0] model_seq;
    retire_rec_t          exp_q [$];
    int                   model_count;
    int                   model_stall_sum;
    int                   model_max;

    pipe_trace_top u_pipe_trace_top (
        .clk           (clk),
        .rst           (rst),
        .issue         (issue),
        .issue_word    (issue_word),
        .stall         (stall),
        .log_hold      (log_hold),
        .fetch_free    (fetch_free),
        .rec_valid     (rec_valid),
        .rec           (rec),
        .retired_count (retired_count),
        .stall_total   (stall_total),
        .max_stall     (max_stall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic bit roll_below(input int pct);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return (r % 100) < pct;
    endfunction

    function automatic bit pipe_busy();
        for (int i = 0; i < `PT_NUM_STAGES; i++) begin
            if (model_stg[i].valid) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("FAILED time %0t %s: got %0h, expected %0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < `PT_NUM_STAGES; i++) begin
            model_stg[i] = '0;
        end
        model_seq       = '0;
        model_count     = 0;
        model_stall_sum = 0;
        model_max       = 0;
        exp_q.delete();
    endtask

    // One clock of the stage rules, applied to the inputs driven for the next edge
    task automatic step_model(input bit stall_now, input bit take,
                              input logic [`PT_WORD_W-1:0] word);
        retire_rec_t done;
        int          sum;
        int          i;
        if (model_stg[WB].valid) begin
            done.seq           = model_stg[WB].seq;
            done.word          = model_stg[WB].word;
            done.fetch_stalls  = model_stg[WB].fetch_stalls;
            done.decode_stalls = model_stg[WB].decode_stalls;
            exp_q.push_back(done);
            sum = done.fetch_stalls + done.decode_stalls;
            model_count++;
            model_stall_sum += sum;
            if (sum > model_max) begin
                model_max = sum;
            end
        end
        for (i = WB; i > EX; i--) begin
            model_stg[i] = model_stg[i-1];
        end
        if (stall_now) begin
            model_stg[EX] = '0;
            if (model_stg[FE].valid && model_stg[FE].fetch_stalls != STALL_MAX) begin
                model_stg[FE].fetch_stalls = model_stg[FE].fetch_stalls + 1'b1;
            end
            if (model_stg[DE].valid && model_stg[DE].decode_stalls != STALL_MAX) begin
                model_stg[DE].decode_stalls = model_stg[DE].decode_stalls + 1'b1;
            end
        end else begin
            model_stg[EX] = model_stg[DE];
            model_stg[DE] = model_stg[FE];
            model_stg[FE] = '0;
            if (take) begin
                model_stg[FE].valid = 1'b1;
                model_stg[FE].seq   = model_seq;
                model_stg[FE].word  = word;
            end
        end
        if (take) begin
            model_seq = model_seq + 1'b1;
        end
    endtask

    // Compare a published record with the oldest expected one
    task automatic check_record();
        retire_rec_t head;
        if (rec_valid === 1'b1) begin
            test_recs++;
            if (test_recs == 1) begin
                first_seq = rec.seq;
            end
            if (rec.fetch_stalls == STALL_MAX) begin
                sat_fetch_seen = 1'b1;
            end
            if (rec.decode_stalls == STALL_MAX) begin
                sat_decode_seen = 1'b1;
            end
            check_count++;
            assert (exp_q.size() != 0) else begin
                $display("Record with seq %0h appeared while none was expected", rec.seq);
                error_count++;
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                check_value("rec.seq", rec.seq, head.seq);
                check_value("rec.word", rec.word, head.word);
                check_value("rec.fetch_stalls", rec.fetch_stalls, head.fetch_stalls);
                check_value("rec.decode_stalls", rec.decode_stalls, head.decode_stalls);
            end
        end
    endtask

    task automatic run_cycle(input int stall_pct, input int hold_pct, input bit allow_issue);
        bit                    stall_now;
        bit                    hold_now;
        bit                    take;
        logic [`PT_WORD_W-1:0] word;
        @(negedge clk);
        check_record();
        stall_now = roll_below(stall_pct);
        hold_now  = roll_below(hold_pct);
        word      = $random(seed);
        stall     = stall_now;
        log_hold  = hold_now;
        // Let fetch_free settle on the new stall level
        #1;
        take = allow_issue && (fetch_free === 1'b1);
        if (!stall_now && fetch_free === 1'b0) begin
            saw_free_low = 1'b1;
        end
        if (stall_now) begin
            check_value("fetch_free", fetch_free, 32'd0);
        end
        issue      = take;
        issue_word = word;
        step_model(stall_now, take, word);
    endtask

    task automatic apply_reset(input int cycles);
        @(negedge clk);
        rst      = 1'b1;
        issue    = 1'b0;
        stall    = 1'b0;
        log_hold = 1'b0;
        repeat (cycles) @(negedge clk);
        rst = 1'b0;
        clear_model();
    endtask

    task automatic open_test();
        err_base        = error_count;
        test_recs       = 0;
        saw_free_low    = 1'b0;
        sat_fetch_seen  = 1'b0;
        sat_decode_seen = 1'b0;
    endtask

    // Drain what is in flight, then compare the totals
    task automatic close_test(input string name);
        int waited;
        waited = 0;
        while (!timed_out && (exp_q.size() != 0 || pipe_busy())) begin
            run_cycle(0, 0, 1'b0);
            waited++;
            if (waited >= DRAIN_LIMIT) begin
                $display("Timeout: test %s still had records outstanding after %0d cycles",
                         name, waited);
                timed_out = 1'b1;
            end
        end
        // A few idle cycles catch duplicated records
        repeat (4) run_cycle(0, 0, 1'b0);
        check_value("retired_count", retired_count, model_count);
        check_value("stall_total", stall_total, model_stall_sum);
        check_value("max_stall", max_stall, model_max);
        $display("Test %s: %0d records, %0d errors", name, test_recs, error_count - err_base);
    endtask

    task automatic test_in_order();
        open_test();
        repeat (60) begin
            run_cycle(0, 0, 1'b1);
            // Nothing stalls and the FIFO drains every cycle
            check_value("fetch_free", fetch_free, 32'd1);
        end
        close_test("in-order flow");
    endtask

    task automatic test_random_stall();
        open_test();
        repeat (200) run_cycle(30, 0, 1'b1);
        close_test("random stall");
    endtask

    task automatic test_saturation();
        open_test();
        // Two instructions fill fetch and decode, then a long freeze
        repeat (2) run_cycle(0, 0, 1'b1);
        repeat (20) run_cycle(100, 0, 1'b0);
        close_test("stall saturation");
        check_count++;
        assert (sat_fetch_seen && sat_decode_seen) else begin
            $display("No record showed saturated fetch and decode stall counts");
            error_count++;
        end
    endtask

    task automatic test_back_pressure();
        open_test();
        repeat (30) run_cycle(0, 100, 1'b1);
        repeat (120) run_cycle(20, 50, 1'b1);
        check_count++;
        assert (saw_free_low) else begin
            $display("fetch_free never dropped while log_hold was held");
            error_count++;
        end
        close_test("log hold back-pressure");
    endtask

    task automatic test_mid_reset();
        open_test();
        repeat (40) run_cycle(20, 70, 1'b1);
        apply_reset(4);
        #1;
        check_value("rec_valid", rec_valid, 32'd0);
        check_value("retired_count", retired_count, 32'd0);
        check_value("stall_total", stall_total, 32'd0);
        check_value("max_stall", max_stall, 32'd0);
        check_value("fetch_free", fetch_free, 32'd1);
        test_recs = 0;
        repeat (20) run_cycle(0, 0, 1'b1);
        check_value("first seq after reset", first_seq, 32'd0);
        close_test("mid-run reset");
    endtask

    initial begin
        seed        = 32'hef93;
        check_count = 0;
        error_count = 0;
        timed_out   = 1'b0;
        rst         = 1'b1;
        issue       = 1'b0;
        issue_word  = '0;
        stall       = 1'b0;
        log_hold    = 1'b0;
        clear_model();
        apply_reset(16);

        if (!timed_out) test_in_order();
        if (!timed_out) test_random_stall();
        if (!timed_out) test_saturation();
        if (!timed_out) test_back_pressure();
        if (!timed_out) test_mid_reset();

        $display("Checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+rtl
rtl/pipe_trace_pkg.sv
rtl/stage_tracker.sv
rtl/retire_fifo.sv
rtl/retire_stats.sv
rtl/pipe_trace_top.sv
dv/pipe_trace_assert.sv
dv/pipe_trace_tb.sv
